//--- common/z80_alu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Z80 ALU shared definitions
// Opcodes, flag bit positions and the unit class test
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package z80_alu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Operation codes
    // ~~~~~~~~~~~~~~~~~~~~
    // Arithmetic and logic group first, then the CB-page shifts
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_adc = 4'd1,
        op_sub = 4'd2,
        op_sbc = 4'd3,
        op_and = 4'd4,
        op_xor = 4'd5,
        op_or  = 4'd6,
        op_cp  = 4'd7,
        op_rlc = 4'd8,
        op_rrc = 4'd9,
        op_rl  = 4'd10,
        op_rr  = 4'd11,
        op_sla = 4'd12,
        op_sra = 4'd13,
        op_srl = 4'd14
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Flag byte layout
    // ~~~~~~~~~~~~~~~~~~~~
    // Standard Z80 F register, bit 0 is carry
    localparam int unsigned flag_c  = 0;
    // Add/subtract, used by DAA on a full core
    localparam int unsigned flag_n  = 1;
    // Parity or overflow, chosen per operation
    localparam int unsigned flag_pv = 2;
    // Undocumented copy of bit 3
    localparam int unsigned flag_f3 = 3;
    // Half carry out of the low nibble
    localparam int unsigned flag_h  = 4;
    // Undocumented copy of bit 5
    localparam int unsigned flag_f5 = 5;
    localparam int unsigned flag_z  = 6;
    localparam int unsigned flag_s  = 7;

    // ~~~~~~~~~~~~~~~~~~~~
    // Unit class
    // ~~~~~~~~~~~~~~~~~~~~
    // True for the seven shift and rotate opcodes
    // Everything else belongs to the arithmetic unit
    function automatic logic is_shift_op(alu_op_t op);
        logic shift_class;
        case (op)
            op_rlc, op_rrc, op_rl, op_rr,
            op_sla, op_sra, op_srl: shift_class = 1'b1;
            default:                shift_class = 1'b0;
        endcase
        return shift_class;
    endfunction

endpackage

`default_nettype wire

//--- common/alu_stage_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Stage-1 result bundle from one ALU unit to the flag stage
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface alu_stage_if;
    logic       valid;
    logic [7:0] res;
    logic       carry;
    logic       half;
    logic       ovf;
    // N flag as the unit sees it
    logic       sub;
    // Selects parity instead of overflow for P/V
    logic       logic_op;
    // Z and S sources, CP needs these apart from res
    logic       zero;
    logic       sign;
    // Undocumented bits 5 and 3
    logic       f5;
    logic       f3;

    // Producing unit drives the whole bundle
    modport unit (output valid, res, carry, half, ovf, sub, logic_op,
                  output zero, sign, f5, f3);
    // Flag stage only looks
    modport comb (input valid, res, carry, half, ovf, sub, logic_op,
                  input zero, sign, f5, f3);
endinterface

`default_nettype wire

//--- design/alu_arith.sv
// ~~~~~~~~~~~~~~~~~~~~
// Arithmetic and logic unit, stage 1
// Add, subtract, logic and compare with carry, half carry, overflow
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_valid,
    input  z80_alu_pkg::alu_op_t  alu_op,
    input  logic [7:0]            operand_a,
    input  logic [7:0]            operand_b,
    input  logic                  carry_in,
    alu_stage_if.unit             st
);
    import z80_alu_pkg::*;

    logic       take;
    logic       cin_eff;
    logic       is_sub;
    logic [8:0] sum9;
    logic [4:0] sum5;
    logic [7:0] res_d;
    logic       carry_d;
    logic       half_d;
    logic       ovf_d;
    logic       logic_d;

    // This unit owns every non-shift opcode
    assign take = op_valid && !is_shift_op(alu_op);

    // ~~~~~~~~~~~~~~~~~~~~
    // Adder and logic
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        // Carry only enters ADC and SBC
        cin_eff = (alu_op == op_adc || alu_op == op_sbc) ? carry_in : 1'b0;
        is_sub  = (alu_op == op_sub || alu_op == op_sbc || alu_op == op_cp);
        if (is_sub) begin
            // Bit 8 and bit 4 come out as borrows
            sum9  = {1'b0, operand_a} - {1'b0, operand_b} - {8'd0, cin_eff};
            sum5  = {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]} - {4'd0, cin_eff};
            // Signs differ and result sign flips away from A
            ovf_d = (operand_a[7] != operand_b[7]) && (sum9[7] != operand_a[7]);
        end else begin
            sum9  = {1'b0, operand_a} + {1'b0, operand_b} + {8'd0, cin_eff};
            sum5  = {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]} + {4'd0, cin_eff};
            // Same signs in, other sign out
            ovf_d = (operand_a[7] == operand_b[7]) && (sum9[7] != operand_a[7]);
        end
        res_d   = sum9[7:0];
        carry_d = sum9[8];
        half_d  = sum5[4];
        logic_d = 1'b0;
        // Logic group overrides the adder, C always cleared
        case (alu_op)
            op_and: begin
                res_d   = operand_a & operand_b;
                carry_d = 1'b0;
                half_d  = 1'b1;
                logic_d = 1'b1;
            end
            op_xor: begin
                res_d   = operand_a ^ operand_b;
                carry_d = 1'b0;
                half_d  = 1'b0;
                logic_d = 1'b1;
            end
            op_or: begin
                res_d   = operand_a | operand_b;
                carry_d = 1'b0;
                half_d  = 1'b0;
                logic_d = 1'b1;
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) st.valid <= 1'b0;
        else        st.valid <= take;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            // CP hands back A, its flags still come from the difference
            st.res      <= (alu_op == op_cp) ? operand_a : res_d;
            st.carry    <= carry_d;
            st.half     <= half_d;
            st.ovf      <= ovf_d;
            st.sub      <= is_sub;
            st.logic_op <= logic_d;
            st.zero     <= (res_d == 8'd0);
            st.sign     <= res_d[7];
            // Compare copies bits 5 and 3 from the operand
            st.f5       <= (alu_op == op_cp) ? operand_b[flag_f5] : res_d[flag_f5];
            st.f3       <= (alu_op == op_cp) ? operand_b[flag_f3] : res_d[flag_f3];
        end
    end

endmodule

`default_nettype wire

//--- design/alu_shift.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shift and rotate unit, stage 1
// One-bit rotates and shifts with the shifted-out carry
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu_shift (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_valid,
    input  z80_alu_pkg::alu_op_t  alu_op,
    input  logic [7:0]            operand_a,
    input  logic                  carry_in,
    alu_stage_if.unit             st
);
    import z80_alu_pkg::*;

    logic       take;
    logic [7:0] res_d;
    logic       carry_d;

    // Claims only the shift class
    assign take = op_valid && is_shift_op(alu_op);

    // ~~~~~~~~~~~~~~~~~~~~
    // Shifter
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        // Left moves lose bit 7, right moves lose bit 0
        carry_d = operand_a[7];
        res_d   = operand_a;
        case (alu_op)
            // Rotate around, bit 7 wraps to bit 0
            op_rlc: res_d = {operand_a[6:0], operand_a[7]};
            op_rrc: begin
                res_d   = {operand_a[0], operand_a[7:1]};
                carry_d = operand_a[0];
            end
            // Rotate through the carry
            op_rl:  res_d = {operand_a[6:0], carry_in};
            op_rr: begin
                res_d   = {carry_in, operand_a[7:1]};
                carry_d = operand_a[0];
            end
            op_sla: res_d = {operand_a[6:0], 1'b0};
            // Arithmetic right keeps the sign
            op_sra: begin
                res_d   = {operand_a[7], operand_a[7:1]};
                carry_d = operand_a[0];
            end
            op_srl: begin
                res_d   = {1'b0, operand_a[7:1]};
                carry_d = operand_a[0];
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) st.valid <= 1'b0;
        else        st.valid <= take;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            st.res      <= res_d;
            st.carry    <= carry_d;
            // H and N always clear after a shift
            st.half     <= 1'b0;
            st.sub      <= 1'b0;
            st.ovf      <= 1'b0;
            // P/V shows parity
            st.logic_op <= 1'b1;
            st.zero     <= (res_d == 8'd0);
            st.sign     <= res_d[7];
            st.f5       <= res_d[flag_f5];
            st.f3       <= res_d[flag_f3];
        end
    end

endmodule

`default_nettype wire

//--- design/alu_flags.sv
// ~~~~~~~~~~~~~~~~~~~~
// Flag stage, picks the valid unit result
// Builds the F byte and registers result, flags and valid
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu_flags (
    input  logic        clk,
    input  logic        rst_n,
    alu_stage_if.comb   arith,
    alu_stage_if.comb   shift,
    output logic [7:0]  result,
    output logic [7:0]  flags,
    output logic        result_valid
);
    import z80_alu_pkg::*;

    logic       use_arith;
    logic       any_valid;
    logic [7:0] sel_res;
    logic       sel_logic;
    logic       sel_ovf;
    logic [7:0] flags_d;

    // An opcode has one class, so at most one side is valid
    assign use_arith = arith.valid;
    assign any_valid = arith.valid || shift.valid;

    // ~~~~~~~~~~~~~~~~~~~~
    // Flag byte
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sel_res   = use_arith ? arith.res      : shift.res;
        sel_logic = use_arith ? arith.logic_op : shift.logic_op;
        sel_ovf   = use_arith ? arith.ovf      : shift.ovf;

        flags_d = 8'd0;
        // S and Z come from the unit, CP sources them apart from res
        flags_d[flag_s]  = use_arith ? arith.sign  : shift.sign;
        flags_d[flag_z]  = use_arith ? arith.zero  : shift.zero;
        flags_d[flag_f5] = use_arith ? arith.f5    : shift.f5;
        flags_d[flag_h]  = use_arith ? arith.half  : shift.half;
        flags_d[flag_f3] = use_arith ? arith.f3    : shift.f3;
        // Even parity sets P/V for logic and shifts
        flags_d[flag_pv] = sel_logic ? ~^sel_res : sel_ovf;
        flags_d[flag_n]  = use_arith ? arith.sub   : shift.sub;
        flags_d[flag_c]  = use_arith ? arith.carry : shift.carry;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result       <= 8'd0;
            flags        <= 8'd0;
            result_valid <= 1'b0;
        end else begin
            // Strobe lasts one cycle per operation
            result_valid <= any_valid;
            // Idle cycles hold the last result
            if (any_valid) begin
                result <= sel_res;
                flags  <= flags_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/z80_alu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Z80 ALU slice, top level
// Two parallel stage-1 units feeding one flag stage
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module z80_alu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // One-cycle issue strobe, no handshake
    input  logic                  op_valid,
    input  z80_alu_pkg::alu_op_t  alu_op,
    input  logic [7:0]            operand_a,
    input  logic [7:0]            operand_b,
    input  logic                  carry_in,
    // Two cycles after the issue edge
    output logic [7:0]            result,
    output logic [7:0]            flags,
    output logic                  result_valid
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage-1 bundles
    // ~~~~~~~~~~~~~~~~~~~~
    alu_stage_if arith_st ();
    alu_stage_if shift_st ();

    // ~~~~~~~~~~~~~~~~~~~~
    // Execution units
    // ~~~~~~~~~~~~~~~~~~~~
    // Both see every issue, each keeps its own class
    alu_arith alu_arith (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .alu_op    (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .carry_in  (carry_in),
        .st        (arith_st.unit)
    );

    // Shifts only take A
    alu_shift alu_shift (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .alu_op    (alu_op),
        .operand_a (operand_a),
        .carry_in  (carry_in),
        .st        (shift_st.unit)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Flags and outputs
    // ~~~~~~~~~~~~~~~~~~~~
    alu_flags alu_flags (
        .clk          (clk),
        .rst_n        (rst_n),
        .arith        (arith_st.comb),
        .shift        (shift_st.comb),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- test/z80_alu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the Z80 ALU slice
// Replays the trace file and checks every result, flag byte and latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module z80_alu_tb;
    import z80_alu_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int reset_cycles  = 16;

    logic       clk;
    logic       rst_n;
    logic       op_valid;
    alu_op_t    alu_op;
    logic [7:0] operand_a;
    logic [7:0] operand_b;
    logic       carry_in;
    logic [7:0] result;
    logic [7:0] flags;
    logic       result_valid;

    // One entry per trace vector in each column queue
    logic [3:0] vec_op[$];
    logic [7:0] vec_a[$];
    logic [7:0] vec_b[$];
    logic       vec_cin[$];
    logic [7:0] vec_res[$];
    logic [7:0] vec_flags[$];
    logic       vec_burst[$];

    // Operations in flight with the oldest first
    logic [7:0] exp_res[$];
    logic [7:0] exp_flags[$];
    int         exp_due[$];
    int         exp_idx[$];

    // Rising edges seen so far
    int cycle_cnt    = 0;
    bit trace_loaded = 1'b0;

    z80_alu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .carry_in     (carry_in),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] want, input string where);
        assert (got === want) else
            abort_run($sformatf("error: %s got 0x%02h expected 0x%02h (%s)",
                                name, got, want, where));
    endtask

    task automatic load_trace();
        int    fd;
        int    code;
        int    f_op, f_a, f_b, f_cin, f_res, f_flags, f_burst;
        string line;
        fd = $fopen("test/z80_alu_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open the trace file test/z80_alu_trace.txt");
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0) begin
                code = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_op, f_a, f_b, f_cin, f_res, f_flags, f_burst);
                // Comment and blank lines give fewer fields
                if (code == 7) begin
                    vec_op.push_back(f_op[3:0]);
                    vec_a.push_back(f_a[7:0]);
                    vec_b.push_back(f_b[7:0]);
                    vec_cin.push_back(f_cin[0]);
                    vec_res.push_back(f_res[7:0]);
                    vec_flags.push_back(f_flags[7:0]);
                    vec_burst.push_back(f_burst[0]);
                end
            end
        end
        $fclose(fd);
        if (vec_op.size() == 0)
            abort_run("the trace file holds no vectors");
    endtask

    // Called on a falling edge so that the next rising edge is the issue edge
    task automatic issue_vector(input int i);
        op_valid  = 1'b1;
        alu_op    = alu_op_t'(vec_op[i]);
        operand_a = vec_a[i];
        operand_b = vec_b[i];
        carry_in  = vec_cin[i];
        exp_res.push_back(vec_res[i]);
        exp_flags.push_back(vec_flags[i]);
        // Units register one edge later and the flag stage two edges later
        exp_due.push_back(cycle_cnt + 2);
        exp_idx.push_back(i);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        int gap;
        void'($urandom(28387));
        clk       = 1'b0;
        rst_n     = 1'b0;
        op_valid  = 1'b0;
        alu_op    = op_add;
        operand_a = 8'h00;
        operand_b = 8'h00;
        carry_in  = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        // Outputs keep their reset values until the first issue
        repeat (4) begin
            @(negedge clk);
            compare_byte("result_valid", {7'd0, result_valid}, 8'h00, "after reset");
            compare_byte("result", result, 8'h00, "after reset");
            compare_byte("flags", flags, 8'h00, "after reset");
        end
        for (int i = 0; i < vec_op.size(); i++) begin
            // Occasional idle cycles but none inside a burst
            if (!vec_burst[i] && ($urandom % 4 == 0)) begin
                gap      = 1 + $urandom % 2;
                op_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            issue_vector(i);
            @(negedge clk);
        end
        op_valid = 1'b0;
        // The last result is due two edges after its issue edge
        // Three more idle cycles expose any stray strobe
        repeat (5) @(negedge clk);
        if (exp_due.size() != 0) begin
            abort_run("operations still in flight at the end of the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Result checker
    // ~~~~~~~~~~~~~~~~~~~~
    // Outputs change on rising edges and are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (result_valid) begin
                assert (exp_due.size() != 0) else
                    abort_run("result_valid went high with no operation in flight");
                assert (exp_due[0] == cycle_cnt) else
                    abort_run($sformatf("vector %0d finished at cycle %0d, not at cycle %0d",
                                        exp_idx[0], cycle_cnt, exp_due[0]));
                compare_byte("result", result, exp_res[0],
                             $sformatf("vector %0d", exp_idx[0]));
                compare_byte("flags", flags, exp_flags[0],
                             $sformatf("vector %0d", exp_idx[0]));
                void'(exp_res.pop_front());
                void'(exp_flags.pop_front());
                void'(exp_due.pop_front());
                void'(exp_idx.pop_front());
            end else if (exp_due.size() != 0) begin
                assert (exp_due[0] > cycle_cnt) else
                    abort_run($sformatf("vector %0d never raised result_valid", exp_idx[0]));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Watchdog
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        wait (trace_loaded);
        #(clk_period_ns * (vec_op.size() * 3 + 50));
        abort_run($sformatf("run timed out after %0d cycles", vec_op.size() * 3 + 50));
    end

endmodule

`default_nettype wire

//--- test/z80_alu_trace.txt
// op a b cin result flags burst, all hex, op is the alu_op_t code
// burst 1 issues the vector on the cycle right after the one before it
0 7f 01 0 80 94 0
0 12 34 0 46 00 0
0 ff 01 0 00 51 0
0 80 80 0 00 45 0
0 28 08 0 30 30 0
0 0a 0c 0 16 10 0
1 7f 00 1 80 94 0
1 ff 00 1 00 51 0
1 3c 0f 1 4c 18 0
2 80 01 0 7f 3e 0
2 00 01 0 ff bb 0
2 55 55 0 00 42 0
2 50 20 0 30 22 0
2 10 01 0 0f 1a 0
3 00 00 1 ff bb 0
3 80 00 1 7f 3e 0
3 44 22 0 22 22 0
3 10 10 0 00 42 0
4 f0 3c 0 30 34 0
4 55 aa 0 00 54 0
4 ff 81 0 81 94 0
4 0f 07 0 07 10 0
5 5a ff 0 a5 a4 0
5 12 12 0 00 44 0
5 01 00 0 01 00 0
5 08 20 0 28 2c 0
6 80 01 0 81 84 0
6 00 00 0 00 44 0
6 30 08 0 38 28 0
7 42 42 0 42 42 0
7 10 28 0 10 bb 0
7 80 01 0 80 16 0
7 00 ff 0 00 3b 0
8 81 00 0 03 05 0
8 40 00 0 80 80 0
9 01 00 0 80 81 0
9 3c 00 0 1e 0c 0
a 80 00 0 00 45 0
a 80 00 1 01 01 0
a 15 00 1 2b 2c 0
b 01 00 0 00 45 0
b 01 00 1 80 81 0
b 22 00 1 91 80 0
c 81 00 0 02 01 0
c 54 00 0 a8 a8 0
d 81 00 0 c0 85 0
d 40 00 0 20 20 0
e 81 00 0 40 01 0
e 01 00 0 00 45 0
e fe 00 0 7f 28 0
0 7f 01 0 80 94 1
8 81 00 0 03 05 1
2 00 01 0 ff bb 1
e 81 00 0 40 01 1
5 5a ff 0 a5 a4 1
b 01 00 1 80 81 1
7 10 28 0 10 bb 1
c 54 00 0 a8 a8 1
1 ff 00 1 00 51 1
d 81 00 0 c0 85 1

//--- z80_alu.f
common/z80_alu_pkg.sv
common/alu_stage_if.sv
design/alu_arith.sv
design/alu_shift.sv
design/alu_flags.sv
design/z80_alu_top.sv
test/z80_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the z80_alu testbench with Verilator and run it
# The exit status is nonzero when the log shows a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f z80_alu.f --top-module z80_alu_tb \
    -o z80_alu_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/z80_alu_sim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
